// File: frame_decoder.f
source/frame_decoder_pkg.sv
source/header_capture.sv
source/payload_realigner.sv
source/congestion_marker.sv
source/output_sequencer.sv
source/frame_decoder.sv
sim/frame_decoder_sva.sv
sim/frame_decoder_tb.sv

// File: sim/frame_decoder_sva.sv
module frame_decoder_sva
    import frame_decoder_pkg::*;
(
    input logic                glb_clk,
    input logic                glb_areset_n,
    input logic                s_valid,
    input axis_beat_t          s_beat,
    input logic                s_ready,
    input logic                m_valid,
    input axis_beat_t          m_beat,
    input logic [port_num-1:0] bus_sel
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // at most one output port, steady while a frame goes out
    a_sel_onehot: assert property (@(posedge glb_clk) disable iff (!glb_areset_n)
        $onehot0(bus_sel) && (!(m_valid && $past(m_valid)) || $stable(bus_sel)))
        else begin
            fail_count++;
            $error("bus_sel not one-hot or changed during a frame");
        end

    // last only on a valid beat, and the frame stops there
    a_last_valid: assert property (@(posedge glb_clk) disable iff (!glb_areset_n)
        (!m_beat.last || m_valid) && !($past(m_valid && m_beat.last) && m_valid))
        else begin
            fail_count++;
            $error("m_beat.last without m_valid or m_valid after the last beat");
        end

    // input closes right after the last beat
    a_ready_drop: assert property (@(posedge glb_clk) disable iff (!glb_areset_n)
        (s_valid && s_ready && s_beat.last) |=> !s_ready)
        else begin
            fail_count++;
            $error("s_ready still high after the last input beat");
        end

endmodule

bind frame_decoder frame_decoder_sva i_frame_decoder_sva (.*);

// File: sim/frame_decoder_tb.sv
module frame_decoder_tb
    import frame_decoder_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [7:0]  label;
        logic [7:0]  ecn;
        logic [15:0] len_type;
        logic [3:0]  pay_len;
        fill_vec_t   fill;
        logic        ready_w0;
        logic        exp_mark;
    } row_t;

    localparam int rows       = 16;
    localparam int wait_limit = 100;

    logic                glb_clk = 1'b0;
    logic                glb_areset_n;
    logic                s_valid;
    axis_beat_t          s_beat;
    logic                s_ready;
    logic                m_valid;
    axis_beat_t          m_beat;
    logic                m_ready;
    logic [port_num-1:0] bus_sel;
    fill_vec_t           fifo_used;

    row_t        tbl [rows];
    axis_beat_t  in_beats[$];
    axis_beat_t  got[$];
    logic [7:0]  pay_bytes[$];
    logic [31:0] rng = 32'ha4d4;
    logic        input_done;
    int          cur_row;
    int          err_count = 0;
    int          check_count = 0;

    frame_decoder i_frame_decoder (.*);

    always #4 glb_clk = ~glb_clk;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // named port gets sel_fill, the others sit on the far side of the threshold
    function automatic row_t make_row(input logic [7:0] label, input logic [7:0] ecn,
            input logic [3:0] pay_len, input logic [31:0] sel_fill,
            input logic ready_w0, input logic exp_mark);
        row_t r;
        r.label    = label;
        r.ecn      = ecn;
        r.len_type = {8'h08, 4'h0, pay_len};
        r.pay_len  = pay_len;
        r.ready_w0 = ready_w0;
        r.exp_mark = exp_mark;
        for (int p = 0; p < port_num; p++) begin
            r.fill[p] = (sel_fill > 32'd3000) ? 32'd120 : 32'd5000 + p;
        end
        if (label >= 8'd1 && label <= 8'd8) begin
            r.fill[label - 8'd1] = sel_fill;
        end
        return r;
    endfunction

    function automatic logic [port_num-1:0] expected_sel(input row_t r);
        logic [port_num-1:0] sel;
        sel = '0;
        if (r.label >= 8'd1 && r.label <= 8'd8) begin
            sel[r.label - 8'd1] = 1'b1;
        end
        return sel;
    endfunction

    // --------------------------------------------------
    // reporting
    // --------------------------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] got_v,
            input logic [31:0] exp_v);
        err_count++;
        $display("** Error: %s (row %0d) got %h, expected %h", name, cur_row, got_v, exp_v);
    endtask

    task automatic finish_run();
        int sva_fails;
        sva_fails = i_frame_decoder.i_frame_decoder_sva.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, err_count, sva_fails);
        if (err_count + sva_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic abort_run(input string msg);
        err_count++;
        $display("row %0d timed out: %s", cur_row, msg);
        finish_run();
    endtask

    // --------------------------------------------------
    // frame stimulus
    // --------------------------------------------------
    task automatic build_frame(input row_t r);
        axis_beat_t b;
        int         len;
        int         n;
        len = r.pay_len;
        in_beats.delete();
        pay_bytes.delete();
        // MAC words are random, they pass through untouched
        for (int i = 0; i < 3; i++) begin
            rng = next_rand(rng);
            in_beats.push_back('{data: rng, keep: 4'hf, last: 1'b0});
        end
        in_beats.push_back('{data: {r.label, r.ecn, r.len_type}, keep: 4'hf, last: 1'b0});
        for (int i = 0; i < len; i += 4) begin
            rng = next_rand(rng);
            n = (len - i > 4) ? 4 : len - i;
            b.data = rng;
            b.keep = 4'hf >> (4 - n);
            b.last = (i + 4 >= len);
            in_beats.push_back(b);
            for (int k = 0; k < n; k++) begin
                pay_bytes.push_back(rng[8*k +: 8]);
            end
        end
    endtask

    task automatic send_frame();
        int  idx;
        int  waited;
        logic accepted;
        idx    = 0;
        waited = 0;
        s_valid = 1'b1;
        while (idx < in_beats.size()) begin
            s_beat   = in_beats[idx];
            // registered ready, so this value holds at the coming rising edge
            accepted = s_ready;
            @(negedge glb_clk);
            if (accepted) begin
                idx++;
                waited = 0;
            end else if (++waited > wait_limit) begin
                abort_run("s_ready never went high");
            end
        end
        s_valid    = 1'b0;
        input_done <= 1'b1;
    endtask

    task automatic collect_frame(input logic [port_num-1:0] exp_sel);
        int waited;
        got.delete();
        waited = 0;
        while (!m_valid) begin
            @(negedge glb_clk);
            if (++waited > wait_limit) begin
                abort_run("no m_valid for the frame");
            end
        end
        waited = 0;
        while (!i_frame_decoder.frame_done) begin
            if (m_valid) begin
                got.push_back(m_beat);
                if (bus_sel !== exp_sel) begin
                    report_mismatch("bus_sel", 32'(bus_sel), 32'(exp_sel));
                end
            end
            if (input_done && s_ready) begin
                report_mismatch("s_ready", 32'(s_ready), 32'h0);
            end
            @(negedge glb_clk);
            if (++waited > wait_limit) begin
                abort_run("frame never completed");
            end
        end
    endtask

    // --------------------------------------------------
    // reference model and compare
    // --------------------------------------------------
    task automatic check_frame(input row_t r);
        axis_beat_t  exp;
        logic [31:0] mask;
        int          rem;
        int          count;
        int          n;
        rem = r.pay_len - 1;
        // a one-byte payload still closes with an empty last beat
        count = r.ready_w0 ? hdr_words + ((rem == 0) ? 1 : (rem + 3) / 4) : 1;
        if (got.size() != count) begin
            err_count++;
            $display("row %0d: %0d output beats instead of %0d", cur_row, got.size(), count);
        end
        for (int w = 0; w < got.size() && w < count; w++) begin
            check_count++;
            if (w < 3) begin
                exp = in_beats[w];
            end else if (w == 3) begin
                exp.data = {pay_bytes[0], r.exp_mark ? ecn_marked : r.ecn, r.len_type};
                exp.keep = 4'hf;
                exp.last = 1'b0;
            end else begin
                n = rem - 4 * (w - 4);
                n = (n > 4) ? 4 : n;
                exp.data = '0;
                exp.keep = 4'hf >> (4 - n);
                exp.last = (w == count - 1);
                for (int k = 0; k < n; k++) begin
                    exp.data[8*k +: 8] = pay_bytes[1 + 4 * (w - 4) + k];
                end
            end
            for (int k = 0; k < 4; k++) begin
                mask[8*k +: 8] = {8{exp.keep[k]}};
            end
            if ((got[w].data & mask) !== exp.data) begin
                report_mismatch($sformatf("m_beat.data word %0d", w), got[w].data & mask,
                                exp.data);
            end
            if (got[w].keep !== exp.keep) begin
                report_mismatch($sformatf("m_beat.keep word %0d", w), 32'(got[w].keep),
                                32'(exp.keep));
            end
            if (got[w].last !== exp.last) begin
                report_mismatch($sformatf("m_beat.last word %0d", w), 32'(got[w].last),
                                32'(exp.last));
            end
        end
    endtask

    initial begin
        glb_areset_n = 1'b0;
        s_valid      = 1'b0;
        s_beat       = '0;
        m_ready      = 1'b1;
        fifo_used    = '0;
        input_done   = 1'b0;
        cur_row      = -1;
        tbl[0]  = make_row(8'd1,  8'h22, 4'd1,  32'd3001,      1'b1, 1'b1);
        tbl[1]  = make_row(8'd2,  8'h35, 4'd2,  32'd3000,      1'b1, 1'b0);
        tbl[2]  = make_row(8'd3,  8'h40, 4'd3,  32'd2999,      1'b1, 1'b0);
        tbl[3]  = make_row(8'd4,  8'h03, 4'd4,  32'hffff_ffff, 1'b1, 1'b1);
        tbl[4]  = make_row(8'd5,  8'h5a, 4'd5,  32'd0,         1'b1, 1'b0);
        tbl[5]  = make_row(8'd6,  8'h00, 4'd6,  32'd4000,      1'b1, 1'b1);
        tbl[6]  = make_row(8'd7,  8'h7e, 4'd7,  32'd3000,      1'b1, 1'b0);
        tbl[7]  = make_row(8'd8,  8'h81, 4'd8,  32'd3001,      1'b1, 1'b1);
        tbl[8]  = make_row(8'd0,  8'h92, 4'd9,  32'd0,         1'b1, 1'b0);
        tbl[9]  = make_row(8'd9,  8'ha5, 4'd10, 32'd0,         1'b1, 1'b0);
        tbl[10] = make_row(8'hfe, 8'hb6, 4'd11, 32'd0,         1'b1, 1'b0);
        tbl[11] = make_row(8'hff, 8'hc7, 4'd12, 32'd0,         1'b1, 1'b0);
        tbl[12] = make_row(8'd3,  8'hd8, 4'd13, 32'd3500,      1'b0, 1'b1);
        tbl[13] = make_row(8'd4,  8'he9, 4'd13, 32'd10,        1'b1, 1'b0);
        tbl[14] = make_row(8'd6,  8'hf1, 4'd5,  32'd2000,      1'b0, 1'b0);
        tbl[15] = make_row(8'd1,  8'h12, 4'd11, 32'd3001,      1'b1, 1'b1);
        repeat (3) @(negedge glb_clk);
        glb_areset_n = 1'b1;
        if (m_valid !== 1'b0) report_mismatch("m_valid", 32'(m_valid), 32'h0);
        if (s_ready !== 1'b0) report_mismatch("s_ready", 32'(s_ready), 32'h0);
        if (bus_sel !== '0) report_mismatch("bus_sel", 32'(bus_sel), 32'h0);
        for (int i = 0; i < rows; i++) begin
            cur_row    = i;
            build_frame(tbl[i]);
            fifo_used  = tbl[i].fill;
            m_ready    = tbl[i].ready_w0;
            input_done = 1'b0;
            fork
                send_frame();
                collect_frame(expected_sel(tbl[i]));
            join
            m_ready = 1'b1;
            check_frame(tbl[i]);
        end
        finish_run();
    end

endmodule

// File: source/congestion_marker.sv
module congestion_marker
    import frame_decoder_pkg::*;
(
    input  frame_hdr_t          hdr,
    input  fill_vec_t           fifo_used,
    output logic [port_num-1:0] bus_sel,
    output logic [7:0]          ecn_out
);

    logic [7:0]                  label_off;
    logic                        in_range;
    logic [$clog2(port_num)-1:0] port_idx;

    // labels below label_first wrap to a large offset
    assign label_off = hdr.label - label_first;
    assign in_range  = label_off < 8'(port_num);
    assign port_idx  = label_off[$clog2(port_num)-1:0];

    always_comb begin
        bus_sel = '0;
        if (in_range) begin
            bus_sel[port_idx] = 1'b1;
        end
    end

    // mark when the selected FIFO is filling up
    always_comb begin
        if (in_range && (fifo_used[port_idx] > fifo_alert_threshold)) begin
            ecn_out = ecn_marked;
        end else begin
            ecn_out = hdr.ecn;
        end
    end

endmodule

// File: source/frame_decoder.sv
module frame_decoder
    import frame_decoder_pkg::*;
(
    input  logic                glb_clk,
    input  logic                glb_areset_n,

    // input stream
    input  logic                s_valid,
    input  axis_beat_t          s_beat,
    output logic                s_ready,

    // output stream
    output logic                m_valid,
    output axis_beat_t          m_beat,
    input  logic                m_ready,

    // port select and congestion inputs
    output logic [port_num-1:0] bus_sel,
    input  fill_vec_t           fifo_used
);

    frame_hdr_t  hdr;
    logic        hdr_done;
    logic        pay_start;
    logic [7:0]  pay_l0;
    axis_beat_t  pay_beat;
    logic        pay_valid;
    logic [7:0]  ecn_out;
    logic        frame_done;

    header_capture i_header_capture (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .s_valid      (s_valid),
        .s_beat       (s_beat),
        .frame_done   (frame_done),
        .s_ready      (s_ready),
        .hdr          (hdr),
        .hdr_done     (hdr_done),
        .pay_start    (pay_start)
    );

    payload_realigner i_payload_realigner (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .s_beat       (s_beat),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .pay_start    (pay_start),
        .pay_l0       (pay_l0),
        .pay_beat     (pay_beat),
        .pay_valid    (pay_valid)
    );

    congestion_marker i_congestion_marker (
        .hdr          (hdr),
        .fifo_used    (fifo_used),
        .bus_sel      (bus_sel),
        .ecn_out      (ecn_out)
    );

    output_sequencer i_output_sequencer (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .hdr          (hdr),
        .hdr_done     (hdr_done),
        .ecn_out      (ecn_out),
        .pay_l0       (pay_l0),
        .pay_beat     (pay_beat),
        .pay_valid    (pay_valid),
        .m_ready      (m_ready),
        .m_valid      (m_valid),
        .m_beat       (m_beat),
        .frame_done   (frame_done)
    );

endmodule

// File: source/frame_decoder_pkg.sv
package frame_decoder_pkg;

    // --------------------------------------------------
    // stream and port sizes
    // --------------------------------------------------
    localparam int data_w   = 32;
    localparam int keep_w   = 4;
    localparam int mac_w    = 48;
    localparam int port_num = 8;
    localparam int fill_w   = 32;

    // congestion marking
    localparam logic [fill_w-1:0] fifo_alert_threshold = 32'd3000;
    localparam logic [7:0]        ecn_marked           = 8'h01;

    // label of output port 0, the others follow in order
    localparam logic [7:0] label_first = 8'd1;

    // words ahead of the payload on the output
    localparam int hdr_words = 4;

    // --------------------------------------------------
    // types
    // --------------------------------------------------
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [keep_w-1:0] keep;
        logic              last;
    } axis_beat_t;

    typedef struct packed {
        logic [mac_w-1:0] dst_mac;
        logic [mac_w-1:0] src_mac;
        logic [15:0]      len_type;
        logic [7:0]       ecn;
        logic [7:0]       label;
    } frame_hdr_t;

    // field view of beat 3, label in the top byte
    typedef struct packed {
        logic [7:0]  label;
        logic [7:0]  ecn;
        logic [15:0] len_type;
    } tag_fields_t;

    typedef union packed {
        logic [data_w-1:0] raw;
        tag_fields_t       f;
    } tag_word_u;

    // one fill count per output port FIFO
    typedef logic [port_num-1:0][fill_w-1:0] fill_vec_t;

endpackage

// File: source/header_capture.sv
module header_capture
    import frame_decoder_pkg::*;
(
    input  logic       glb_clk,
    input  logic       glb_areset_n,
    input  logic       s_valid,
    input  axis_beat_t s_beat,
    input  logic       frame_done,
    output logic       s_ready,
    output frame_hdr_t hdr,
    output logic       hdr_done,
    output logic       pay_start
);

    typedef enum logic [2:0] {
        rx_idle,
        rx_dst,
        rx_split,
        rx_src,
        rx_tag,
        rx_payload,
        rx_wait_done
    } rx_state_t;

    rx_state_t        rx_state;
    logic             accept;
    logic             tag_seen_q;
    tag_word_u        tag_word;
    logic [mac_w-1:0] dst_mac_q;
    logic [mac_w-1:0] src_mac_q;
    logic [15:0]      len_type_q;
    logic [7:0]       ecn_q;
    logic [7:0]       label_q;

    assign accept       = s_valid && s_ready;
    assign tag_word.raw = s_beat.data;

    // --------------------------------------------------
    // receive FSM and input ready
    // --------------------------------------------------
    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            rx_state   <= rx_idle;
            s_ready    <= 1'b0;
            tag_seen_q <= 1'b0;
            label_q    <= '0;
        end else begin
            tag_seen_q <= 1'b0;
            case (rx_state)
                rx_idle: begin
                    if (s_valid) begin
                        s_ready  <= 1'b1;
                        rx_state <= rx_dst;
                    end
                end
                rx_dst:   if (accept) rx_state <= rx_split;
                rx_split: if (accept) rx_state <= rx_src;
                rx_src:   if (accept) rx_state <= rx_tag;
                rx_tag: begin
                    if (accept) begin
                        label_q    <= tag_word.f.label;
                        tag_seen_q <= 1'b1;
                        rx_state   <= rx_payload;
                    end
                end
                rx_payload: begin
                    // close the input until the frame has left
                    if (accept && s_beat.last) begin
                        s_ready  <= 1'b0;
                        rx_state <= rx_wait_done;
                    end
                end
                rx_wait_done: begin
                    if (frame_done) begin
                        // label 0 selects no port
                        label_q  <= '0;
                        rx_state <= rx_idle;
                    end
                end
                default: rx_state <= rx_idle;
            endcase
        end
    end

    // MAC halves meet across the split beat
    always_ff @(posedge glb_clk) begin
        if (accept) begin
            case (rx_state)
                rx_dst: dst_mac_q[31:0] <= s_beat.data;
                rx_split: begin
                    dst_mac_q[47:32] <= s_beat.data[15:0];
                    src_mac_q[15:0]  <= s_beat.data[31:16];
                end
                rx_src: src_mac_q[47:16] <= s_beat.data;
                rx_tag: begin
                    len_type_q <= tag_word.f.len_type;
                    ecn_q      <= tag_word.f.ecn;
                end
                default: ;
            endcase
        end
    end

    assign hdr = '{dst_mac: dst_mac_q, src_mac: src_mac_q, len_type: len_type_q,
                   ecn: ecn_q, label: label_q};

    // first payload beat is on the input while these are high
    assign hdr_done  = tag_seen_q;
    assign pay_start = tag_seen_q;

endmodule

// File: source/output_sequencer.sv
module output_sequencer
    import frame_decoder_pkg::*;
(
    input  logic       glb_clk,
    input  logic       glb_areset_n,
    input  frame_hdr_t hdr,
    input  logic       hdr_done,
    input  logic [7:0] ecn_out,
    input  logic [7:0] pay_l0,
    input  axis_beat_t pay_beat,
    input  logic       pay_valid,
    input  logic       m_ready,
    output logic       m_valid,
    output axis_beat_t m_beat,
    output logic       frame_done
);

    typedef enum logic [2:0] {
        tx_idle,
        tx_word0,
        tx_word1,
        tx_word2,
        tx_word3,
        tx_payload,
        tx_drop
    } tx_state_t;

    tx_state_t         tx_state;
    logic              pay_end;
    logic              in_hdr;
    logic [data_w-1:0] hdr_word;

    assign pay_end = pay_valid && pay_beat.last;
    assign in_hdr  = (tx_state == tx_word0) || (tx_state == tx_word1) ||
                     (tx_state == tx_word2) || (tx_state == tx_word3);

    // --------------------------------------------------
    // transmit FSM
    // --------------------------------------------------
    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            tx_state   <= tx_idle;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (tx_state)
                tx_idle: begin
                    if (hdr_done) begin
                        tx_state <= tx_word0;
                    end
                end
                tx_word0: begin
                    // refused at word 0, the whole frame goes
                    if (m_ready) begin
                        tx_state <= tx_word1;
                    end else begin
                        tx_state <= tx_drop;
                    end
                end
                tx_word1: tx_state <= tx_word2;
                tx_word2: tx_state <= tx_word3;
                tx_word3: tx_state <= tx_payload;
                tx_payload, tx_drop: begin
                    if (pay_end) begin
                        tx_state   <= tx_idle;
                        frame_done <= 1'b1;
                    end
                end
                default: tx_state <= tx_idle;
            endcase
        end
    end

    // header words, label byte removed from word 3
    always_comb begin
        case (tx_state)
            tx_word0: hdr_word = hdr.dst_mac[31:0];
            tx_word1: hdr_word = {hdr.src_mac[15:0], hdr.dst_mac[47:32]};
            tx_word2: hdr_word = hdr.src_mac[47:16];
            default:  hdr_word = {pay_l0, ecn_out, hdr.len_type};
        endcase
    end

    always_comb begin
        m_valid = 1'b0;
        m_beat  = '0;
        if (in_hdr) begin
            m_valid     = 1'b1;
            m_beat.data = hdr_word;
            m_beat.keep = '1;
        end else if ((tx_state == tx_payload) && pay_valid) begin
            m_valid = 1'b1;
            m_beat  = pay_beat;
        end
    end

endmodule

// File: source/payload_realigner.sv
module payload_realigner
    import frame_decoder_pkg::*;
(
    input  logic       glb_clk,
    input  logic       glb_areset_n,
    input  axis_beat_t s_beat,
    input  logic       s_valid,
    input  logic       s_ready,
    input  logic       pay_start,
    output logic [7:0] pay_l0,
    output axis_beat_t pay_beat,
    output logic       pay_valid
);

    logic                       accept;
    logic                       active_q;
    logic                       tail_pend_q;
    logic [keep_w-1:0]          tail_keep_q;
    logic [data_w-9:0]          hold_q;
    axis_beat_t                 st0_beat_q;
    logic                       st0_valid_q;
    axis_beat_t [hdr_words-2:0] dly_beat_q;
    logic [hdr_words-2:0]       dly_valid_q;

    assign accept = s_valid && s_ready;

    // --------------------------------------------------
    // byte shift control
    // --------------------------------------------------
    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            active_q    <= 1'b0;
            tail_pend_q <= 1'b0;
            st0_valid_q <= 1'b0;
            dly_valid_q <= '0;
        end else begin
            st0_valid_q <= 1'b0;
            if (pay_start && accept) begin
                // a one-beat payload goes straight to the tail
                active_q    <= !s_beat.last;
                tail_pend_q <= s_beat.last;
            end else if (tail_pend_q) begin
                tail_pend_q <= 1'b0;
                st0_valid_q <= 1'b1;
            end else if (active_q && accept) begin
                st0_valid_q <= 1'b1;
                if (s_beat.last) begin
                    active_q    <= 1'b0;
                    tail_pend_q <= (s_beat.keep != keep_w'(1));
                end
            end
            dly_valid_q <= {dly_valid_q[hdr_words-3:0], st0_valid_q};
        end
    end

    // upper three bytes wait for the low byte of the next beat
    always_ff @(posedge glb_clk) begin
        if (pay_start && accept) begin
            pay_l0      <= s_beat.data[7:0];
            hold_q      <= s_beat.data[data_w-1:8];
            tail_keep_q <= {1'b0, s_beat.keep[keep_w-1:1]};
        end else if (tail_pend_q) begin
            st0_beat_q <= '{data: {8'h00, hold_q}, keep: tail_keep_q, last: 1'b1};
        end else if (active_q && accept) begin
            st0_beat_q.data <= {s_beat.data[7:0], hold_q};
            st0_beat_q.keep <= '1;
            st0_beat_q.last <= s_beat.last && (s_beat.keep == keep_w'(1));
            hold_q          <= s_beat.data[data_w-1:8];
            tail_keep_q     <= {1'b0, s_beat.keep[keep_w-1:1]};
        end
        dly_beat_q <= {dly_beat_q[hdr_words-3:0], st0_beat_q};
    end

    // --------------------------------------------------
    // delay line puts the payload right behind word 3
    // --------------------------------------------------
    assign pay_beat  = dly_beat_q[hdr_words-2];
    assign pay_valid = dly_valid_q[hdr_words-2];

endmodule
